/* sources.f */
verilog/fd_pkg.sv
verilog/fd_key_ram.sv
verilog/fd_decrypt.sv
verilog/fd_regs.sv
verilog/fd_key_ctrl.sv
verilog/fd_top.sv
bench/fd_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the testbench with verilator, run it, look for the pass line
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal --top-module fd_tb -f sources.f
out=$(./obj_dir/Vfd_tb)
printf '%s\n' "$out"
echo "$out" | grep -qx "Finished with no errors"

/* bench/fd_tb.sv */
// testbench for the fd1094-style key-state subsystem
//   clock, reset, axi4-lite write and read tasks, cpu fetch task
//   lcg stimulus, reference decrypt and key-state model
//   compare process on dec, watchdog

`timescale 1ns/1ns

module fd_tb;

    localparam int n_mixed = 200;    // steps of the mixed stream
    // register 9, bypass 32, key load 65, decrypt 64, state 32, irq 39
    // then up to 4 per mixed step and the closing read
    localparam int n_trans = 9 + 32 + 65 + 64 + 32 + 39 + 4 * n_mixed + 1;
    // cmpi.l #imm uses ea field 111100
    localparam logic [15:0] cmpi_l_imm = {fd_pkg::op_cmpi_hi, fd_pkg::op_size_long, 6'b111100};

    logic        clk;
    logic        rst;
    logic [11:0] awaddr;
    logic        awvalid;
    logic        awready;
    logic [31:0] wdata;
    logic [3:0]  wstrb;
    logic        wvalid;
    logic        wready;
    logic [1:0]  bresp;
    logic        bvalid;
    logic        bready;
    logic [11:0] araddr;
    logic        arvalid;
    logic        arready;
    logic [31:0] rdata;
    logic [1:0]  rresp;
    logic        rvalid;
    logic        rready;
    logic [23:1] addr;
    logic [15:0] enc;
    logic        op_n;
    logic        inta_n;
    logic        sup_prog;
    logic        dtackn;
    logic [15:0] dec;

    // testbench copies of what was written, plus model of the controller
    logic [7:0]  key_copy [0:63];
    logic [7:0]  gkey0_copy;
    logic        enable_copy;
    logic [7:0]  m_state;
    logic        m_irq;
    logic [1:0]  m_stage;     // 0 idle, 1 waiting for command word, 2 for closing word
    logic [5:0]  m_next;
    logic [15:0] m_cmd;
    logic [15:0] exp_dec;     // expected dec of the fetch on the bus
    logic [31:0] lcg;
    int          n_checks;
    int          n_errors;

    fd_top uut (.*);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    initial begin
        #(n_trans * 40 * 4);
        $display("watchdog expired, test sequence did not complete");
        $display("Finished with errors");
        $finish;
    end

    task automatic report_mismatch(input string name, input logic [31:0] got,
                                   input logic [31:0] expected);
        n_errors++;
        $display("ERROR %0t ns %s got %h expected %h", $time, name, got, expected);
    endtask

    task automatic report_failure(input string msg);
        n_errors++;
        $display("%0t ns: %s", $time, msg);
    endtask

    function automatic logic [31:0] lcg_next();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return lcg ^ (lcg >> 16);   // fold high bits down since low bits are weak
    endfunction

    // opcode fetch mixes in state and data fetch uses key only
    function automatic logic [7:0] ref_mask(input logic opn, input logic [7:0] k,
                                            input logic [7:0] s);
        return opn ? k : (k ^ s);
    endfunction

    // xor cipher so the same function also encrypts
    function automatic logic [15:0] ref_decrypt(input logic [15:0] e, input logic opn,
                                                input logic en, input logic [7:0] k,
                                                input logic [7:0] s);
        logic [7:0] m;
        m = ref_mask(opn, k, s);
        return en ? (e ^ {m, m}) : e;
    endfunction

    function automatic logic [7:0] model_st();
        return m_irq ? gkey0_copy : m_state;
    endfunction

    // one edge of the key-state model
    // done marks a completed supervisor cycle
    task automatic model_step(input logic done, input logic opn, input logic [5:0] alo,
                              input logic [15:0] w, input logic ack);
        logic idle;
        logic adv;
        idle = m_stage == 2'd0;
        adv  = done && !idle && alo == m_next;
        if (done && !opn && idle) begin
            if (w[15:8] == fd_pkg::op_cmpi_hi && w[7:6] == fd_pkg::op_size_long) begin
                m_stage = 2'd1;
                m_next  = alo + 6'd1;
            end
            if (w == fd_pkg::op_rte)
                m_irq = 1'b0;
        end
        if (ack)
            m_irq = 1'b1;
        if (adv && m_stage == 2'd1) begin
            m_stage = 2'd2;
            m_next  = alo + 6'd1;
            m_cmd   = w;                  // command word
        end else if (adv) begin
            m_stage = 2'd0;
            if (w == fd_pkg::op_cmd_end) begin
                case (m_cmd[9:8])
                    fd_pkg::cmd_set:       m_state = m_cmd[7:0];
                    fd_pkg::cmd_reset: begin
                        m_state = 8'h00;
                        m_irq   = 1'b0;
                    end
                    fd_pkg::cmd_irq_enter: m_irq = 1'b1;
                    default:               m_irq = 1'b0;
                endcase
            end
        end
    endtask

    task automatic axi_write(input logic [11:0] a, input logic [31:0] d, input int bdelay);
        awaddr  = a;
        awvalid = 1'b1;
        wdata   = d;
        wstrb   = 4'hf;
        wvalid  = 1'b1;
        bready  = (bdelay == 0);
        @(negedge clk);
        while (!(awready && wready))
            @(negedge clk);
        @(posedge clk);                   // accept edge
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
        @(negedge clk);
        while (!bvalid)
            @(negedge clk);
        assert (bresp == 2'b00) else report_mismatch("bresp", 32'(bresp), 32'h0);
        if (bdelay > 0) begin
            repeat (bdelay) @(posedge clk);
            #1 bready = 1'b1;
            @(negedge clk);
            assert (bvalid) else report_failure("bvalid dropped before bready");
        end
        @(posedge clk);                   // response taken
        #1 bready = 1'b0;
    endtask

    task automatic axi_read_check(input logic [11:0] a, input logic [31:0] expected,
                                  input int rdelay);
        araddr  = a;
        arvalid = 1'b1;
        rready  = (rdelay == 0);
        @(negedge clk);
        while (!arready)
            @(negedge clk);
        @(posedge clk);
        #1 arvalid = 1'b0;
        @(negedge clk);
        while (!rvalid)
            @(negedge clk);
        if (rdelay > 0) begin
            repeat (rdelay) @(posedge clk);   // back-pressure on r
            #1 rready = 1'b1;
            @(negedge clk);
            assert (rvalid) else report_failure("rvalid dropped before rready");
        end
        n_checks++;
        assert (rdata == expected) else report_mismatch("rdata", rdata, expected);
        assert (rresp == 2'b00) else report_mismatch("rresp", 32'(rresp), 32'h0);
        @(posedge clk);
        #1 rready = 1'b0;
    endtask

    // one supervisor bus cycle with dtackn low for a single clock
    task automatic fetch(input logic [15:0] plain, input logic [23:1] a, input logic opn);
        logic [15:0] e;
        e = ref_decrypt(plain, opn, enable_copy, key_copy[a[6:1]], model_st());
        exp_dec  = ref_decrypt(e, opn, enable_copy, key_copy[a[6:1]], model_st());
        addr     = a;
        enc      = e;
        op_n     = opn;
        sup_prog = 1'b1;
        dtackn   = 1'b0;
        @(posedge clk);
        model_step(1'b1, opn, a[6:1], exp_dec, 1'b0);
        #1;
        dtackn = 1'b1;
        op_n   = 1'b1;
    endtask

    task automatic random_fetch();
        logic [31:0] r;
        logic [31:0] a;
        r = lcg_next();
        a = lcg_next();
        fetch(r[15:0], a[22:0], r[31]);
    endtask

    task automatic pulse_inta();
        inta_n = 1'b0;
        @(posedge clk);
        model_step(1'b0, 1'b1, 6'd0, 16'h0000, 1'b1);
        #1 inta_n = 1'b1;
    endtask

    task automatic state_cmd(input logic [23:1] a, input logic [1:0] code,
                             input logic [7:0] val, input logic tail_opn);
        fetch(cmpi_l_imm, a, 1'b0);
        fetch({6'b0, code, val}, a + 23'd1, tail_opn);
        fetch(fd_pkg::op_cmd_end, a + 23'd2, tail_opn);
    endtask

    // walk an armed sequence to its end with harmless data words
    task automatic settle_ctrl();
        while (m_stage != 2'd0)
            fetch(16'h0000, {17'd0, m_next}, 1'b1);
    endtask

    // compare dec mid-cycle while the fetch is on the bus
    always @(negedge clk) begin
        if (!rst && !dtackn) begin
            n_checks++;
            assert (dec === exp_dec) else report_mismatch("dec", 32'(dec), 32'(exp_dec));
        end
    end

    initial begin
        logic [31:0] r;
        logic [31:0] r2;
        int          i;
        rst      = 1'b1;
        awaddr   = '0;
        awvalid  = 1'b0;
        wdata    = '0;
        wstrb    = '0;
        wvalid   = 1'b0;
        bready   = 1'b0;
        araddr   = '0;
        arvalid  = 1'b0;
        rready   = 1'b0;
        addr     = '0;
        enc      = '0;
        op_n     = 1'b1;
        inta_n   = 1'b1;
        sup_prog = 1'b0;
        dtackn   = 1'b1;
        lcg      = 32'd98;
        n_checks = 0;
        n_errors = 0;
        exp_dec  = '0;
        enable_copy = 1'b0;
        gkey0_copy  = 8'h00;
        m_state  = 8'h00;
        m_irq    = 1'b0;
        m_stage  = 2'd0;
        m_next   = 6'd0;
        m_cmd    = 16'h0000;
        repeat (16) @(posedge clk);
        #1 rst = 1'b0;

        // register access
        assert (!awready && !wready && !bvalid && !arready && !rvalid)
            else report_failure("axi handshake outputs not low after reset");
        axi_read_check(fd_pkg::reg_state, 32'h0, 0);
        axi_write(fd_pkg::reg_gkey0, 32'h0000_005a, 3);
        gkey0_copy = 8'h5a;
        axi_read_check(fd_pkg::reg_gkey0, 32'h5a, 2);
        axi_write(fd_pkg::reg_ctrl, 32'h1, 0);
        axi_read_check(fd_pkg::reg_ctrl, 32'h1, 0);
        axi_write(fd_pkg::reg_ctrl, 32'h0, 1);
        axi_read_check(fd_pkg::reg_ctrl, 32'h0, 1);
        axi_read_check(12'h00c, 32'h0, 0);                // unmapped
        axi_read_check(fd_pkg::reg_key_base, 32'h0, 0);   // no key readback

        // bypass
        repeat (32) random_fetch();

        // key load with junk in the upper data bits
        for (i = 0; i < fd_pkg::key_depth; i++) begin
            r = lcg_next();
            key_copy[i] = r[7:0];
            axi_write(fd_pkg::reg_key_base + 12'(4 * i), r, 0);
        end
        axi_write(fd_pkg::reg_ctrl, 32'h1, 0);
        enable_copy = 1'b1;
        repeat (64) random_fetch();

        // state change and a sequence whose middle word is misplaced
        settle_ctrl();
        state_cmd(23'h001234, fd_pkg::cmd_reset, 8'h00, 1'b0);
        state_cmd(23'h000200, fd_pkg::cmd_set, 8'ha7, 1'b1);
        axi_read_check(fd_pkg::reg_state, 32'h0a7, 1);
        fetch(cmpi_l_imm, 23'h000310, 1'b0);
        fetch({6'b0, fd_pkg::cmd_set, 8'h11}, 23'h000313, 1'b1);   // expected at 0x311
        fetch(fd_pkg::op_cmd_end, 23'h000314, 1'b1);
        axi_read_check(fd_pkg::reg_state, 32'h0a7, 0);
        settle_ctrl();
        axi_read_check(fd_pkg::reg_state, 32'h0a7, 0);
        repeat (16) random_fetch();

        // interrupt mode and its three exits
        settle_ctrl();
        axi_write(fd_pkg::reg_gkey0, 32'h3c, 0);
        gkey0_copy = 8'h3c;
        pulse_inta();
        axi_read_check(fd_pkg::reg_state, 32'h13c, 0);
        repeat (16) random_fetch();
        settle_ctrl();
        fetch(fd_pkg::op_rte, 23'h000400, 1'b0);
        axi_read_check(fd_pkg::reg_state, 32'h0a7, 0);
        state_cmd(23'h000500, fd_pkg::cmd_irq_enter, 8'h00, 1'b0);
        axi_read_check(fd_pkg::reg_state, 32'h13c, 0);
        state_cmd(23'h000520, fd_pkg::cmd_irq_leave, 8'h00, 1'b1);
        axi_read_check(fd_pkg::reg_state, 32'h0a7, 0);
        pulse_inta();
        state_cmd(23'h000540, fd_pkg::cmd_reset, 8'h00, 1'b0);
        axi_read_check(fd_pkg::reg_state, 32'h000, 0);

        // mixed stream against the model
        for (i = 0; i < n_mixed; i++) begin
            r  = lcg_next();
            r2 = lcg_next();
            if (r[3:0] < 4'd3)
                state_cmd(r2[22:0], r[5:4], r[15:8], r[6]);
            else if (r[3:0] == 4'd3)
                pulse_inta();
            else
                random_fetch();
            if (r[11:8] == 4'd0)
                axi_read_check(fd_pkg::reg_state, {23'd0, m_irq, model_st()}, int'(r[13:12]));
        end
        axi_read_check(fd_pkg::reg_state, {23'd0, m_irq, model_st()}, 0);

        $display("checks %0d, errors %0d", n_checks, n_errors);
        if (n_errors == 0)
            $display("Finished with no errors");
        else
            $display("Finished with errors");
        $finish;
    end

endmodule

/* verilog/fd_top.sv */
// fd1094-style key-state subsystem, top level
//   fd_regs     axi4-lite registers and key window
//   fd_key_ram  64-entry key table
//   fd_decrypt  bus word decryption
//   fd_key_ctrl state byte and interrupt mode tracking

`timescale 1ns/1ns

module fd_top (
    input  logic                      clk,
    input  logic                      rst,
    // axi4-lite slave
    input  logic [fd_pkg::axi_aw-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [fd_pkg::axi_dw-1:0] wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    input  logic [fd_pkg::axi_aw-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [fd_pkg::axi_dw-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // cpu bus
    input  logic [23:1]               addr,
    input  logic [15:0]               enc,
    input  logic                      op_n,
    input  logic                      inta_n,
    input  logic                      sup_prog,
    input  logic                      dtackn,
    output logic [15:0]               dec
);

    logic                      enable;
    logic [fd_pkg::key_w-1:0]  gkey0;
    logic                      key_we;
    logic [fd_pkg::key_aw-1:0] key_waddr;
    logic [fd_pkg::key_w-1:0]  key_wdata;
    logic [fd_pkg::key_w-1:0]  key;        // entry at addr[6:1]
    logic [fd_pkg::key_w-1:0]  st;
    logic                      irqmode;

    fd_regs u_regs (
        .clk(clk), .rst(rst),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready),
        .wdata(wdata), .wstrb(wstrb), .wvalid(wvalid), .wready(wready),
        .bresp(bresp), .bvalid(bvalid), .bready(bready),
        .araddr(araddr), .arvalid(arvalid), .arready(arready),
        .rdata(rdata), .rresp(rresp), .rvalid(rvalid), .rready(rready),
        .st(st), .irqmode(irqmode),
        .enable(enable), .gkey0(gkey0),
        .key_we(key_we), .key_waddr(key_waddr), .key_wdata(key_wdata)
    );

    fd_key_ram u_key_ram (
        .clk(clk), .we(key_we), .waddr(key_waddr), .wdata(key_wdata),
        .raddr(addr[6:1]), .rdata(key)
    );

    fd_decrypt u_decrypt (
        .enc(enc), .op_n(op_n), .enable(enable), .key(key), .st(st), .dec(dec)
    );

    // controller sees the decrypted word
    fd_key_ctrl u_key_ctrl (
        .clk(clk), .rst(rst), .inta_n(inta_n), .op_n(op_n),
        .addr_lo(addr[6:1]), .dec(dec), .gkey0(gkey0),
        .sup_prog(sup_prog), .dtackn(dtackn),
        .st(st), .irqmode(irqmode)
    );

endmodule

/* verilog/fd_key_ctrl.sv */
// key-state controller
//   spots cmpi.l #data in supervisor opcode fetches
//   latches the command word, runs it on the closing 0xffff
//   rte leaves interrupt mode, interrupt acknowledge enters it
//   st shows gkey0 in interrupt mode, the state byte otherwise

`timescale 1ns/1ns

module fd_key_ctrl (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     inta_n,    // interrupt acknowledge
    input  logic                     op_n,      // low on opcode fetch
    input  logic [fd_pkg::key_aw-1:0] addr_lo,  // cpu addr[6:1]
    input  logic [15:0]              dec,       // decrypted bus word
    input  logic [fd_pkg::key_w-1:0] gkey0,
    input  logic                     sup_prog,  // supervisor program space
    input  logic                     dtackn,    // low completes the bus cycle
    output logic [fd_pkg::key_w-1:0] st,
    output logic                     irqmode
);

    fd_pkg::opword_u           w;          // decrypted word, two views
    fd_pkg::opword_u           stcode;     // latched command word
    logic [fd_pkg::key_w-1:0]  state;
    logic [1:0]                stchange;   // one-hot step, 0 when idle
    logic [fd_pkg::key_aw-1:0] next_addr;  // where the next step must land

    logic cycle_done;
    logic op_fetch;
    logic is_cmpi_l;
    logic is_rte;
    logic is_end;
    logic addr_good;
    logic stadv;

    assign w = dec;

    assign cycle_done = !dtackn && sup_prog;         // completed supervisor cycle
    assign op_fetch   = cycle_done && !op_n;
    assign is_cmpi_l  = w.op.hi == fd_pkg::op_cmpi_hi && w.op.size == fd_pkg::op_size_long;
    assign is_rte     = w.raw == fd_pkg::op_rte;
    assign is_end     = w.raw == fd_pkg::op_cmd_end;
    assign addr_good  = addr_lo == next_addr;
    assign stadv      = cycle_done && addr_good && stchange != 2'b00;

    // gkey0 replaces the state while servicing an interrupt
    assign st = irqmode ? gkey0 : state;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state     <= '0;
            irqmode   <= 1'b0;
            stchange  <= 2'b00;
            next_addr <= '0;
        end else begin
            // idle: look for the opening cmpi.l, or rte
            if (op_fetch && stchange == 2'b00) begin
                if (is_cmpi_l) begin
                    stchange  <= 2'b01;
                    next_addr <= addr_lo + 1'b1;
                end
                if (is_rte)
                    irqmode <= 1'b0;
            end
            if (!inta_n)
                irqmode <= 1'b1;    // ack, same edge
            // armed: step on a cycle at the expected address
            if (stadv) begin
                stchange <= stchange << 1;
                if (stchange[0])
                    next_addr <= addr_lo + 1'b1;
                // closing word runs the command, anything else drops it
                if (stchange[1] && is_end) begin
                    case (stcode.cmd.code)
                        fd_pkg::cmd_set:
                            state <= stcode.cmd.value;
                        fd_pkg::cmd_reset: begin
                            state   <= '0;
                            irqmode <= 1'b0;
                        end
                        fd_pkg::cmd_irq_enter:
                            irqmode <= 1'b1;
                        default:             // cmd_irq_leave
                            irqmode <= 1'b0;
                    endcase
                end
            end
        end
    end

    // command word, payload only
    always_ff @(posedge clk) begin
        if (stadv && stchange[0])
            stcode <= w;
    end

endmodule

/* verilog/fd_regs.sv */
// axi4-lite register block
//   ctrl: enable bit
//   gkey0: global key byte used in interrupt mode
//   state: read-only view of st and irqmode
//   key window: writes become one-cycle key table pulses, reads give 0
// single outstanding write and read, responses always okay

`timescale 1ns/1ns

module fd_regs (
    input  logic                      clk,
    input  logic                      rst,
    // write address / data / response
    input  logic [fd_pkg::axi_aw-1:0] awaddr,
    input  logic                      awvalid,
    output logic                      awready,
    input  logic [fd_pkg::axi_dw-1:0] wdata,
    input  logic [3:0]                wstrb,
    input  logic                      wvalid,
    output logic                      wready,
    output logic [1:0]                bresp,
    output logic                      bvalid,
    input  logic                      bready,
    // read address / data
    input  logic [fd_pkg::axi_aw-1:0] araddr,
    input  logic                      arvalid,
    output logic                      arready,
    output logic [fd_pkg::axi_dw-1:0] rdata,
    output logic [1:0]                rresp,
    output logic                      rvalid,
    input  logic                      rready,
    // readback from the controller
    input  logic [fd_pkg::key_w-1:0]  st,
    input  logic                      irqmode,
    // control out
    output logic                      enable,
    output logic [fd_pkg::key_w-1:0]  gkey0,
    output logic                      key_we,
    output logic [fd_pkg::key_aw-1:0] key_waddr,
    output logic [fd_pkg::key_w-1:0]  key_wdata
);

    logic                      wr_acc;      // write accepted this cycle
    logic                      rd_acc;
    logic                      key_hit;     // awaddr in 0x100..0x1fc
    logic [fd_pkg::axi_dw-1:0] rd_mux;

    // accept only with both channels valid and no response held
    assign wr_acc  = awvalid && wvalid && !bvalid;
    assign awready = wr_acc;
    assign wready  = wr_acc;
    assign rd_acc  = arvalid && !rvalid;
    assign arready = rd_acc;

    assign bresp = fd_pkg::resp_okay;
    assign rresp = fd_pkg::resp_okay;

    // key window decode, index from word address
    assign key_hit   = awaddr[fd_pkg::axi_aw-1:8] == fd_pkg::reg_key_base[fd_pkg::axi_aw-1:8];
    assign key_we    = wr_acc && key_hit && wstrb[0];
    assign key_waddr = awaddr[fd_pkg::key_aw+1:2];
    assign key_wdata = wdata[fd_pkg::key_w-1:0];

    // write side
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            bvalid <= 1'b0;
            enable <= 1'b0;
            gkey0  <= '0;
        end else begin
            if (wr_acc)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;     // response taken
            if (wr_acc && wstrb[0]) begin
                if (awaddr == fd_pkg::reg_ctrl)
                    enable <= wdata[0];
                if (awaddr == fd_pkg::reg_gkey0)
                    gkey0 <= wdata[fd_pkg::key_w-1:0];
            end
        end
    end

    // read mux, unmapped and key window give 0
    always_comb begin
        rd_mux = '0;
        case (araddr)
            fd_pkg::reg_ctrl:  rd_mux[0] = enable;
            fd_pkg::reg_gkey0: rd_mux[fd_pkg::key_w-1:0] = gkey0;
            fd_pkg::reg_state: rd_mux[fd_pkg::key_w:0] = {irqmode, st};
            default:           rd_mux = '0;
        endcase
    end

    // read side control
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            rvalid <= 1'b0;
        end else begin
            if (rd_acc)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    // read data held until rready
    always_ff @(posedge clk) begin
        if (rd_acc)
            rdata <= rd_mux;
    end

endmodule

/* verilog/fd_decrypt.sv */
// word decryptor
//   mask byte = key ^ state on opcode fetches, key alone on data fetches
//   mask repeated into both halves and xored onto the bus word
//   bypass when disabled
// purely combinational

`timescale 1ns/1ns

module fd_decrypt (
    input  logic [15:0]              enc,     // encrypted bus word
    input  logic                     op_n,    // low on opcode fetch
    input  logic                     enable,
    input  logic [fd_pkg::key_w-1:0] key,     // table entry at addr[6:1]
    input  logic [fd_pkg::key_w-1:0] st,      // state or gkey0
    output logic [15:0]              dec
);

    logic [fd_pkg::key_w-1:0] mask;
    logic [15:0]              mask_w;
    logic [15:0]              plain;

    // state only takes part on opcode fetches
    always_comb begin
        if (!op_n)
            mask = key ^ st;
        else
            mask = key;
    end

    assign mask_w = {mask, mask};     // same byte in both halves
    assign plain  = enc ^ mask_w;

    // enable clear -> word untouched
    assign dec = enable ? plain : enc;

endmodule

/* verilog/fd_key_ram.sv */
// key table
//   one byte per entry, 64 entries picked by addr[6:1]
//   registered write from the axi side
//   asynchronous read for the decryptor
// contents undefined until loaded

`timescale 1ns/1ns

module fd_key_ram (
    input  logic                      clk,
    input  logic                      we,      // one-cycle write pulse
    input  logic [fd_pkg::key_aw-1:0] waddr,
    input  logic [fd_pkg::key_w-1:0]  wdata,
    input  logic [fd_pkg::key_aw-1:0] raddr,   // cpu addr[6:1]
    output logic [fd_pkg::key_w-1:0]  rdata
);

    logic [fd_pkg::key_w-1:0] mem [0:fd_pkg::key_depth-1];

    // write lands on the edge, readable next cycle
    always_ff @(posedge clk) begin
        if (we)
            mem[waddr] <= wdata;
    end

    // same-cycle read, dec depends on it combinationally
    assign rdata = mem[raddr];

endmodule

/* verilog/fd_pkg.sv */
// shared definitions for the fd1094-style key-state subsystem
//   key table sizes and state byte width
//   axi4-lite widths, register map and response code
//   68000 opcode constants used by the state-change detector
//   state-change command codes
//   opword_u, one bus word seen as opcode or as command word

package fd_pkg;

    // key table, indexed by cpu addr[6:1]
    localparam int key_aw    = 6;
    localparam int key_depth = 64;
    localparam int key_w     = 8;     // key entry and state byte

    // axi4-lite
    localparam int axi_aw = 12;
    localparam int axi_dw = 32;
    localparam logic [1:0] resp_okay = 2'b00;

    // register map, byte addresses
    localparam logic [axi_aw-1:0] reg_ctrl     = 12'h000;  // bit 0 enable
    localparam logic [axi_aw-1:0] reg_gkey0    = 12'h004;  // global key, 7:0
    localparam logic [axi_aw-1:0] reg_state    = 12'h008;  // ro, {irqmode, st}
    localparam logic [axi_aw-1:0] reg_key_base = 12'h100;  // entry i at +4*i

    // opcodes watched by the controller
    localparam logic [7:0]  op_cmpi_hi   = 8'h0c;
    localparam logic [1:0]  op_size_long = 2'b10;
    localparam logic [15:0] op_rte       = 16'h4e73;
    localparam logic [15:0] op_cmd_end   = 16'hffff;  // closes the sequence

    // command codes carried in the middle word
    localparam logic [1:0] cmd_set       = 2'd0;  // load state byte
    localparam logic [1:0] cmd_reset     = 2'd1;  // clear state, leave irq mode
    localparam logic [1:0] cmd_irq_enter = 2'd2;
    localparam logic [1:0] cmd_irq_leave = 2'd3;

    // opcode view: cmpi is 0000 1100 ss eeeeee
    typedef struct packed {
        logic [7:0] hi;
        logic [1:0] size;
        logic [5:0] ea;
    } op_view_t;

    // command view of the immediate word after cmpi.l
    typedef struct packed {
        logic [5:0] unused;
        logic [1:0] code;
        logic [7:0] value;
    } cmd_view_t;

    typedef union packed {
        logic [15:0] raw;
        op_view_t    op;
        cmd_view_t   cmd;
    } opword_u;

endpackage
